// File: rtl/prbs_link_pkg.sv
`default_nettype none

package prbs_link_pkg;

    //////////////////////////////////////////////////
    // Board geometry
    //////////////////////////////////////////////////

    // Transceiver lanes on the board
    localparam int NUM_LANES = 8;
    // Only lanes 4 to 7 reach the front-panel LEDs
    localparam int LED_LANES = 4;
    // CCB cable width, bits 34-35 are not wired
    localparam int CCB_WIDTH = 51;

    // CCB command codes, carried in bits 7:2 of the bus
    localparam logic [5:0] CMD_BX0     = 6'h01;
    localparam logic [5:0] CMD_RESYNC  = 6'h03;
    localparam logic [5:0] CMD_BXRESET = 6'h32;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [NUM_LANES-1:0] lane_vec_t;
    // Saturating error count of one lane
    typedef logic [1:0] err_cnt_t;
    typedef err_cnt_t [NUM_LANES-1:0] err_cnt_vec_t;

    // Encoding seen by the transceiver PRBS generator and checker
    typedef enum logic [2:0] {
        PRBS_OFF = 3'd0,
        PRBS7    = 3'd1,
        PRBS15   = 3'd2,
        PRBS23   = 3'd3,
        PRBS31   = 3'd4
    } prbs_mode_e;

    // Boot order, the LED phase code is the state number plus one
    typedef enum logic [2:0] {
        ST_RESET,
        ST_EN_TX,
        ST_TX_DONE,
        ST_EN_RX,
        ST_RX_DONE,
        ST_INJECT,
        ST_INJECT_CLEAR,
        ST_CHECK
    } boot_state_e;

    // One-cycle command pulses
    typedef struct packed {
        logic bx0;
        logic resync;
        logic bxreset;
    } ccb_cmd_t;

    // Controls driven to the transceivers
    typedef struct packed {
        lane_vec_t full_tx_reset;
        lane_vec_t full_rx_reset;
        logic      chk_clear;
        logic      error_inject;
    } link_ctrl_t;

    // APB register offsets
    typedef enum logic [3:0] {
        REG_CTRL   = 4'h0,
        REG_STATUS = 4'h4,
        REG_ERRCNT = 4'h8
    } apb_addr_e;

endpackage

`default_nettype wire

// File: rtl/ccb_cmd_decoder.sv
`default_nettype none

module ccb_cmd_decoder (
    input  logic                                clk40,
    input  logic                                PRBS_reset,
    input  logic [prbs_link_pkg::CCB_WIDTH-1:0] ccb_rx_i,
    output prbs_link_pkg::ccb_cmd_t             cmd_o
);
    import prbs_link_pkg::*;

    logic [CCB_WIDTH-1:0] ccb_q;
    logic [CCB_WIDTH-1:0] ccb;
    logic [5:0]           cmd_code;
    logic                 strobe;
    ccb_cmd_t             cmd_d;

    // Input register at the pins
    // Idle cable is all ones, so reset loads the idle level
    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            ccb_q <= '1;
        end else begin
            ccb_q <= ccb_rx_i;
        end
    end

    // Cable is active low
    // Bits 34-35 float on the board and are forced low
    always_comb begin
        ccb        = ~ccb_q;
        ccb[35:34] = 2'b00;
    end

    assign cmd_code = ccb[7:2];
    // Command strobe
    assign strobe   = ccb[10];

    // Decode only the three codes used here
    always_comb begin
        cmd_d.bx0     = strobe && (cmd_code == CMD_BX0);
        cmd_d.resync  = strobe && (cmd_code == CMD_RESYNC);
        cmd_d.bxreset = strobe && (cmd_code == CMD_BXRESET);
    end

    // Pulses leave registered, one cycle after the input register
    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            cmd_o <= '0;
        end else begin
            cmd_o <= cmd_d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/prbs_error_monitor.sv
`default_nettype none

module prbs_error_monitor (
    input  logic                        clk40,
    input  logic                        PRBS_reset,
    input  prbs_link_pkg::lane_vec_t    prbs_error_i,
    input  logic                        chk_clear_i,
    output prbs_link_pkg::lane_vec_t    err_flags_o,
    output prbs_link_pkg::err_cnt_vec_t err_cnt_o
);
    import prbs_link_pkg::*;

    // Count stops here
    localparam err_cnt_t CNT_MAX = '1;

    //////////////////////////////////////////////////
    // Per-lane sticky flag and saturating count
    //////////////////////////////////////////////////

    // Clear has priority over a new error in the same cycle
    always_ff @(posedge clk40) begin
        if (PRBS_reset || chk_clear_i) begin
            err_flags_o <= '0;
            err_cnt_o   <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (prbs_error_i[i]) begin
                    // Flag stays set until the next clear
                    err_flags_o[i] <= 1'b1;
                    // Counts error cycles, not error bits
                    if (err_cnt_o[i] != CNT_MAX) begin
                        err_cnt_o[i] <= err_cnt_o[i] + 2'd1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/link_config_regs.sv
`default_nettype none

module link_config_regs (
    input  logic                        clk40,
    input  logic                        PRBS_reset,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [3:0]                  paddr_i,
    input  logic [31:0]                 pwdata_i,
    input  prbs_link_pkg::boot_state_e  state_i,
    input  prbs_link_pkg::lane_vec_t    err_flags_i,
    input  prbs_link_pkg::err_cnt_vec_t err_cnt_i,
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output prbs_link_pkg::prbs_mode_e   prbs_mode_o,
    output logic                        sw_inject_o
);
    import prbs_link_pkg::*;

    apb_addr_e addr;
    logic      access;
    logic      mapped;
    logic      wr_ctrl;

    assign addr   = apb_addr_e'(paddr_i);
    // Access phase of a transfer
    assign access = psel_i && penable_i;

    //////////////////////////////////////////////////
    // Read mux and offset decode
    //////////////////////////////////////////////////

    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (addr)
            REG_CTRL: begin
                // Inject bit always reads as zero
                prdata_o[2:0] = prbs_mode_o;
            end
            REG_STATUS: begin
                prdata_o[2:0]  = state_i;
                prdata_o[15:8] = err_flags_i;
            end
            REG_ERRCNT: begin
                prdata_o[15:0] = err_cnt_i;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    // No wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access && !mapped;
    // Writes to the status offsets fall through silently
    assign wr_ctrl   = access && pwrite_i && (addr == REG_CTRL);

    //////////////////////////////////////////////////
    // Control register
    //////////////////////////////////////////////////

    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            prbs_mode_o <= PRBS31;
            sw_inject_o <= 1'b0;
        end else begin
            // Single-cycle pulse per write with bit 3 set
            sw_inject_o <= wr_ctrl && pwdata_i[3];
            if (wr_ctrl) begin
                prbs_mode_o <= prbs_mode_e'(pwdata_i[2:0]);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/link_boot_fsm.sv
`default_nettype none

module link_boot_fsm #(
    parameter int SETTLE_CYCLES = 16,
    parameter int INJECT_CYCLES = 32
) (
    input  logic                        clk40,
    input  logic                        PRBS_reset,
    input  prbs_link_pkg::ccb_cmd_t     cmd_i,
    input  logic                        inject_i,
    input  logic                        sw_inject_i,
    input  prbs_link_pkg::lane_vec_t    tx_reset_done_i,
    input  prbs_link_pkg::lane_vec_t    rx_reset_done_i,
    input  prbs_link_pkg::lane_vec_t    err_flags_i,
    input  prbs_link_pkg::err_cnt_vec_t err_cnt_i,
    output prbs_link_pkg::link_ctrl_t   ctrl_o,
    output prbs_link_pkg::boot_state_e  state_o,
    output logic [7:0]                  led_o
);
    import prbs_link_pkg::*;

    // Counter must reach the longer of the two waits
    localparam int MAX_WAIT = (SETTLE_CYCLES > INJECT_CYCLES) ? SETTLE_CYCLES : INJECT_CYCLES;
    localparam int CNT_W    = $clog2(MAX_WAIT + 1);

    // All lanes held in reset and checkers cleared
    localparam link_ctrl_t CTRL_RESET = '{
        full_tx_reset: '1,
        full_rx_reset: '1,
        chk_clear:     1'b1,
        error_inject:  1'b0
    };

    boot_state_e      state_q;
    boot_state_e      state_d;
    logic [CNT_W-1:0] cnt_q;
    logic             settle_done;
    logic             inject_done;
    link_ctrl_t       ctrl_d;
    logic [7:0]       led_d;
    logic [3:0]       phase_code;

    //////////////////////////////////////////////////
    // State machine and state counter
    //////////////////////////////////////////////////

    // Counter is zero on the first cycle of each state
    assign settle_done = (cnt_q == CNT_W'(SETTLE_CYCLES - 1));
    assign inject_done = (cnt_q == CNT_W'(INJECT_CYCLES - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RESET: begin
                state_d = ST_EN_TX;
            end
            ST_EN_TX: begin
                if (settle_done) begin
                    state_d = ST_TX_DONE;
                end
            end
            ST_TX_DONE: begin
                if (&tx_reset_done_i) begin
                    state_d = ST_EN_RX;
                end
            end
            ST_EN_RX: begin
                if (settle_done) begin
                    state_d = ST_RX_DONE;
                end
            end
            ST_RX_DONE: begin
                if (&rx_reset_done_i) begin
                    state_d = ST_INJECT;
                end
            end
            ST_INJECT: begin
                if (inject_done) begin
                    state_d = ST_INJECT_CLEAR;
                end
            end
            ST_INJECT_CLEAR: begin
                state_d = ST_CHECK;
            end
            default: begin
                state_d = ST_CHECK;
            end
        endcase
        // Resync restarts the boot from any state
        if (cmd_i.resync) begin
            state_d = ST_RESET;
        end
    end

    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            state_q <= ST_RESET;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_d != state_q) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign state_o = state_q;

    //////////////////////////////////////////////////
    // Transceiver controls and LEDs
    //////////////////////////////////////////////////

    always_comb begin
        ctrl_d = '0;
        case (state_q)
            ST_RESET: begin
                ctrl_d = CTRL_RESET;
            end
            ST_EN_TX, ST_TX_DONE: begin
                // TX out of reset, RX still held
                ctrl_d.full_rx_reset = '1;
                ctrl_d.chk_clear     = 1'b1;
            end
            ST_EN_RX, ST_INJECT_CLEAR: begin
                ctrl_d.chk_clear = 1'b1;
            end
            ST_RX_DONE, ST_INJECT: begin
                ctrl_d.error_inject = 1'b1;
            end
            default: begin
                // Checking, clears and injects come from commands
                ctrl_d.chk_clear    = cmd_i.bxreset;
                ctrl_d.error_inject = inject_i || cmd_i.bx0 || sw_inject_i;
            end
        endcase
    end

    assign phase_code = {1'b0, state_q} + 4'd1;

    always_comb begin
        led_d = {phase_code, 4'b0000};
        case (state_q)
            ST_INJECT, ST_INJECT_CLEAR: begin
                // Lane 4 on led 3 down to lane 7 on led 0
                for (int i = 0; i < LED_LANES; i++) begin
                    led_d[LED_LANES-1-i] = err_flags_i[NUM_LANES-LED_LANES+i];
                end
            end
            ST_CHECK: begin
                // One LED pair per lane count, lane 4 on top
                for (int i = 0; i < LED_LANES; i++) begin
                    led_d[7-2*i -: 2] = err_cnt_i[NUM_LANES-LED_LANES+i];
                end
            end
            default: begin
                led_d = {phase_code, 4'b0000};
            end
        endcase
    end

    // Outputs trail the state by one cycle
    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            ctrl_o <= CTRL_RESET;
            led_o  <= 8'h10;
        end else begin
            ctrl_o <= ctrl_d;
            led_o  <= led_d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/prbs_link_ctrl.sv
`default_nettype none

module prbs_link_ctrl #(
    parameter int SETTLE_CYCLES = 16,
    parameter int INJECT_CYCLES = 32
) (
    input  logic                                clk40,
    input  logic                                PRBS_reset,
    input  logic [prbs_link_pkg::CCB_WIDTH-1:0] ccb_rx_i,
    input  logic                                inject_i,
    input  prbs_link_pkg::lane_vec_t            tx_reset_done_i,
    input  prbs_link_pkg::lane_vec_t            rx_reset_done_i,
    input  prbs_link_pkg::lane_vec_t            prbs_error_i,
    output prbs_link_pkg::link_ctrl_t           link_ctrl_o,
    output prbs_link_pkg::prbs_mode_e           prbs_mode_o,
    output logic [7:0]                          led_o,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [3:0]                          paddr_i,
    input  logic [31:0]                         pwdata_i,
    output logic [31:0]                         prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o
);
    import prbs_link_pkg::*;

    ccb_cmd_t     cmd;
    boot_state_e  state;
    link_ctrl_t   link_ctrl;
    lane_vec_t    err_flags;
    err_cnt_vec_t err_cnt;
    logic         sw_inject;

    //////////////////////////////////////////////////
    // Command path
    //////////////////////////////////////////////////

    ccb_cmd_decoder u_ccb_cmd_decoder (
        .clk40      (clk40),
        .PRBS_reset (PRBS_reset),
        .ccb_rx_i   (ccb_rx_i),
        .cmd_o      (cmd)
    );

    // Software side of the board
    link_config_regs u_link_config_regs (
        .clk40       (clk40),
        .PRBS_reset  (PRBS_reset),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .state_i     (state),
        .err_flags_i (err_flags),
        .err_cnt_i   (err_cnt),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .prbs_mode_o (prbs_mode_o),
        .sw_inject_o (sw_inject)
    );

    //////////////////////////////////////////////////
    // Boot sequencer and error monitor
    //////////////////////////////////////////////////

    link_boot_fsm #(
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .INJECT_CYCLES (INJECT_CYCLES)
    ) u_link_boot_fsm (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .cmd_i           (cmd),
        .inject_i        (inject_i),
        .sw_inject_i     (sw_inject),
        .tx_reset_done_i (tx_reset_done_i),
        .rx_reset_done_i (rx_reset_done_i),
        .err_flags_i     (err_flags),
        .err_cnt_i       (err_cnt),
        .ctrl_o          (link_ctrl),
        .state_o         (state),
        .led_o           (led_o)
    );

    // Checker clear from the sequencer also clears the counts
    prbs_error_monitor u_prbs_error_monitor (
        .clk40        (clk40),
        .PRBS_reset   (PRBS_reset),
        .prbs_error_i (prbs_error_i),
        .chk_clear_i  (link_ctrl.chk_clear),
        .err_flags_o  (err_flags),
        .err_cnt_o    (err_cnt)
    );

    assign link_ctrl_o = link_ctrl;

endmodule

`default_nettype wire

// File: bench/prbs_link_ctrl_properties.sv
`default_nettype none

module prbs_link_ctrl_properties (
    input logic                       clk40,
    input logic                       PRBS_reset,
    input prbs_link_pkg::link_ctrl_t  ctrl_o,
    input prbs_link_pkg::boot_state_e state_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import prbs_link_pkg::*;

    // First edge out of reset still holds every TX lane
    tx_reset_after_reset: assert property (@(posedge clk40)
        $fell(PRBS_reset) |-> &ctrl_o.full_tx_reset)
        else $error("full_tx_reset not all ones after reset");

    // RX must stay held while any TX lane is held
    rx_after_tx: assert property (@(posedge clk40) disable iff (PRBS_reset)
        (|ctrl_o.full_tx_reset) |-> (&ctrl_o.full_rx_reset))
        else $error("full_rx_reset dropped while full_tx_reset still set");

    // Outputs trail the state by one cycle
    no_inject_in_reset: assert property (@(posedge clk40) disable iff (PRBS_reset)
        (state_o == ST_RESET) |=> !ctrl_o.error_inject)
        else $error("error_inject high in ST_RESET");

endmodule

`default_nettype wire

// File: bench/prbs_link_ctrl_tb.sv
`default_nettype none

module prbs_link_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import prbs_link_pkg::*;

    localparam int SETTLE = 16;
    localparam int INJECT = 32;
    localparam int N_ERR  = 24;
    // Two boots plus the checking tests and some margin
    localparam int TIMEOUT_CYCLES = 16 + 2 * (3 * SETTLE + 2 * 16 + INJECT + 16) + 300;

    logic                 clk40;
    logic                 PRBS_reset;
    logic [CCB_WIDTH-1:0] ccb_rx_i;
    logic                 inject_i;
    lane_vec_t            tx_reset_done_i;
    lane_vec_t            rx_reset_done_i;
    lane_vec_t            prbs_error_i;
    link_ctrl_t           link_ctrl_o;
    prbs_mode_e           prbs_mode_o;
    logic [7:0]           led_o;
    logic                 psel_i;
    logic                 penable_i;
    logic                 pwrite_i;
    logic [3:0]           paddr_i;
    logic [31:0]          pwdata_i;
    logic [31:0]          prdata_o;
    logic                 pready_o;
    logic                 pslverr_o;

    logic [31:0]  lfsr_state = 32'h43c5;
    int           cycle_count = 0;
    // Transceiver model
    logic [3:0]   tx_delay [NUM_LANES];
    logic [3:0]   rx_delay [NUM_LANES];
    int           tx_age [NUM_LANES];
    int           rx_age [NUM_LANES];
    // Error count model
    err_cnt_vec_t model_cnt;
    lane_vec_t    model_flags;

    prbs_link_ctrl #(
        .SETTLE_CYCLES (SETTLE),
        .INJECT_CYCLES (INJECT)
    ) u_dut (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .ccb_rx_i        (ccb_rx_i),
        .inject_i        (inject_i),
        .tx_reset_done_i (tx_reset_done_i),
        .rx_reset_done_i (rx_reset_done_i),
        .prbs_error_i    (prbs_error_i),
        .link_ctrl_o     (link_ctrl_o),
        .prbs_mode_o     (prbs_mode_o),
        .led_o           (led_o),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .prdata_o        (prdata_o),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o)
    );

    bind link_boot_fsm prbs_link_ctrl_properties u_props (
        .clk40      (clk40),
        .PRBS_reset (PRBS_reset),
        .ctrl_o     (ctrl_o),
        .state_o    (state_o)
    );

    initial begin
        clk40 = 1'b0;
        forever #5 clk40 = ~clk40;
    end

    //////////////////////////////////////////////////
    // Failure reporting and compares
    //////////////////////////////////////////////////

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_state(input string name, input boot_state_e exp, input boot_state_e act);
        if (act !== exp) begin
            report_fail($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_ctrl(input string name, input link_ctrl_t exp, input link_ctrl_t act);
        if (act !== exp) begin
            report_fail($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_cnt(input string name, input err_cnt_vec_t exp, input err_cnt_vec_t act);
        if (act !== exp) begin
            report_fail($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input lane_vec_t exp, input lane_vec_t act);
        if (act !== exp) begin
            report_fail($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_mode(input string name, input prbs_mode_e exp, input prbs_mode_e act);
        if (act !== exp) begin
            report_fail($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_led(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            report_fail($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Run limit
    always @(posedge clk40) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) report_fail("timeout, the run did not finish in time");
    end

    //////////////////////////////////////////////////
    // Random bits and transceiver model
    //////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    // Reset-done rises a random delay after the lane reset is released
    always @(posedge clk40) begin
        #1;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (link_ctrl_o.full_tx_reset[i]) begin
                tx_age[i] = 0;
                tx_reset_done_i[i] = 1'b0;
            end else if (tx_age[i] >= int'(tx_delay[i])) begin
                tx_reset_done_i[i] = 1'b1;
            end else begin
                tx_age[i]++;
            end
            if (link_ctrl_o.full_rx_reset[i]) begin
                rx_age[i] = 0;
                rx_reset_done_i[i] = 1'b0;
            end else if (rx_age[i] >= int'(rx_delay[i])) begin
                rx_reset_done_i[i] = 1'b1;
            end else begin
                rx_age[i]++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////

    // Two-cycle APB transfer
    // Data and error are sampled in the access phase
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk40);
        #1;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk40);
        #1;
        penable_i = 1'b1;
        @(negedge clk40);
        if (pready_o !== 1'b1) report_fail("pready_o low in the APB access phase");
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk40);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    // Cable is active low with the strobe on bit 10
    task automatic send_ccb(input logic [5:0] code);
        logic [CCB_WIDTH-1:0] bus;
        bus       = '0;
        bus[10]   = 1'b1;
        bus[7:2]  = code;
        @(posedge clk40);
        #1;
        ccb_rx_i = ~bus;
        @(posedge clk40);
        #1;
        ccb_rx_i = '1;
    endtask

    task automatic expect_inject_pulse(input string name);
        int n;
        n = 0;
        while (!link_ctrl_o.error_inject && n < 8) begin
            @(negedge clk40);
            n++;
        end
        if (!link_ctrl_o.error_inject) report_fail({"no error_inject pulse after ", name});
        @(negedge clk40);
        if (link_ctrl_o.error_inject) report_fail({"error_inject longer than one cycle after ", name});
    endtask

    //////////////////////////////////////////////////
    // Boot sequence
    //////////////////////////////////////////////////

    task automatic run_boot(input string name);
        logic [31:0] r;
        logic [31:0] rdata;
        logic        err;
        logic        inj_done;
        logic        done;
        logic [3:0]  prev_phase;
        int          cyc;
        int          tx_drop;
        int          rx_drop;
        int          run;
        for (int i = 0; i < NUM_LANES; i++) begin
            rand_bits(4, r);
            tx_delay[i] = r[3:0];
            rand_bits(4, r);
            rx_delay[i] = r[3:0];
        end
        cyc        = 0;
        tx_drop    = -1;
        rx_drop    = -1;
        run        = 0;
        inj_done   = 1'b0;
        done       = 1'b0;
        prev_phase = 4'd0;
        while (!done) begin
            @(negedge clk40);
            cyc++;
            // Phase codes only while the sequencer still drives controls
            if (link_ctrl_o != '0) begin
                if (led_o[7:4] < prev_phase) report_fail({name, " LED phase went backwards"});
                prev_phase = led_o[7:4];
            end
            if (tx_drop < 0 && link_ctrl_o.full_tx_reset == '0) tx_drop = cyc;
            if (rx_drop < 0 && link_ctrl_o.full_rx_reset == '0) begin
                rx_drop = cyc;
                if (tx_drop < 0) report_fail({name, " RX resets dropped before TX resets"});
                if (cyc - tx_drop < SETTLE) report_fail({name, " RX resets dropped before settle"});
                if (tx_reset_done_i != '1) report_fail({name, " RX resets dropped before TX done"});
            end
            if (link_ctrl_o.error_inject) begin
                if (inj_done) report_fail({name, " error_inject high after the window"});
                run++;
            end else if (run > 0) begin
                if (run < INJECT) report_fail({name, " inject window too short"});
                inj_done = 1'b1;
                run      = 0;
            end
            if (inj_done && link_ctrl_o == '0) done = 1'b1;
        end
        check_led({name, " last phase"}, 8'h70, {prev_phase, 4'h0});
        apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
        check_state({name, " status"}, ST_CHECK, boot_state_e'(rdata[2:0]));
    endtask

    task automatic drive_errors();
        logic [31:0] r;
        for (int n = 0; n < N_ERR; n++) begin
            rand_bits(NUM_LANES, r);
            @(posedge clk40);
            #1;
            prbs_error_i = r[NUM_LANES-1:0];
            for (int i = 0; i < NUM_LANES; i++) begin
                if (r[i]) begin
                    model_flags[i] = 1'b1;
                    if (model_cnt[i] != 2'd3) model_cnt[i] = model_cnt[i] + 2'd1;
                end
            end
        end
        @(posedge clk40);
        #1;
        prbs_error_i = '0;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] rdata;
        logic [31:0] r;
        logic        err;
        logic [7:0]  exp_led;
        link_ctrl_t  ctrl_rst;
        prbs_mode_e  mode;
        int          n;
        PRBS_reset      = 1'b1;
        ccb_rx_i        = '1;
        inject_i        = 1'b0;
        tx_reset_done_i = '0;
        rx_reset_done_i = '0;
        prbs_error_i    = '0;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        pwrite_i        = 1'b0;
        paddr_i         = '0;
        pwdata_i        = '0;
        model_cnt       = '0;
        model_flags     = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            tx_delay[i] = '0;
            rx_delay[i] = '0;
        end
        ctrl_rst.full_tx_reset = '1;
        ctrl_rst.full_rx_reset = '1;
        ctrl_rst.chk_clear     = 1'b1;
        ctrl_rst.error_inject  = 1'b0;

        repeat (15) @(posedge clk40);
        @(negedge clk40);
        check_ctrl("reset controls", ctrl_rst, link_ctrl_o);
        check_mode("reset mode", PRBS31, prbs_mode_o);
        @(posedge clk40);
        #1;
        PRBS_reset = 1'b0;

        run_boot("boot 1");
        apb_xfer(1'b0, REG_CTRL, '0, rdata, err);
        check_mode("ctrl readback after reset", PRBS31, prbs_mode_e'(rdata[2:0]));

        // One-cycle inject sources in checking
        @(posedge clk40);
        #1;
        inject_i = 1'b1;
        @(posedge clk40);
        #1;
        inject_i = 1'b0;
        @(negedge clk40);
        expect_inject_pulse("inject_i");
        send_ccb(CMD_BX0);
        expect_inject_pulse("bx0");
        apb_xfer(1'b1, REG_CTRL, 32'h8 | 32'(PRBS31), rdata, err);
        expect_inject_pulse("sw inject");
        check_mode("mode after sw inject", PRBS31, prbs_mode_o);

        // Error counting
        drive_errors();
        apb_xfer(1'b0, REG_ERRCNT, '0, rdata, err);
        check_cnt("errcnt", model_cnt, err_cnt_vec_t'(rdata[15:0]));
        apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
        check_flags("sticky flags", model_flags, lane_vec_t'(rdata[15:8]));
        // Lane 4 on the top pair down to lane 7 on the bottom pair
        exp_led = {model_cnt[4], model_cnt[5], model_cnt[6], model_cnt[7]};
        check_led("count LEDs", exp_led, led_o);

        // bxreset clears counts and flags
        send_ccb(CMD_BXRESET);
        n = 0;
        while (!link_ctrl_o.chk_clear && n < 8) begin
            @(negedge clk40);
            n++;
        end
        if (!link_ctrl_o.chk_clear) report_fail("no chk_clear after bxreset command");
        model_cnt   = '0;
        model_flags = '0;
        apb_xfer(1'b0, REG_ERRCNT, '0, rdata, err);
        check_cnt("errcnt after bxreset", model_cnt, err_cnt_vec_t'(rdata[15:0]));
        apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
        check_flags("flags after bxreset", model_flags, lane_vec_t'(rdata[15:8]));

        // Resync restarts the boot
        send_ccb(CMD_RESYNC);
        n = 0;
        while (link_ctrl_o.full_tx_reset != '1 && n < 8) begin
            @(negedge clk40);
            n++;
        end
        check_ctrl("controls after resync", ctrl_rst, link_ctrl_o);
        run_boot("boot 2");

        // Mode register and unmapped offset
        // Any mode other than the PRBS31 already stored
        rand_bits(2, r);
        mode = prbs_mode_e'(r[1:0]);
        apb_xfer(1'b1, REG_CTRL, 32'(mode), rdata, err);
        @(negedge clk40);
        check_mode("mode output", mode, prbs_mode_o);
        apb_xfer(1'b0, REG_CTRL, '0, rdata, err);
        check_mode("mode readback", mode, prbs_mode_e'(rdata[2:0]));
        apb_xfer(1'b0, 4'hC, '0, rdata, err);
        if (err !== 1'b1) report_fail("pslverr_o not raised for unmapped offset");

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: prbs_link_ctrl.f
rtl/prbs_link_pkg.sv
rtl/ccb_cmd_decoder.sv
rtl/prbs_error_monitor.sv
rtl/link_config_regs.sv
rtl/link_boot_fsm.sv
rtl/prbs_link_ctrl.sv
bench/prbs_link_ctrl_properties.sv
bench/prbs_link_ctrl_tb.sv

// File: Makefile
TOP := prbs_link_ctrl_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f prbs_link_ctrl.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f prbs_link_ctrl.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin > sim.log 2>&1 || true
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
